// File: dv/sdp_wdma_dat_out_sva.sv
/*
 * Concurrent checks on the write-DMA data output top level.
 * Bound to sdp_wdma_dat_out, covers request stability, quiet mode,
 * lane ready and done timing.
 */
`timescale 1ns/1ps

module sdp_wdma_dat_out_sva import sdp_wdma_pkg::*; (
  input logic       nvdla_core_clk,
  input logic       nvdla_core_rstn,
  input dma_req_t   dma_wr_req_pd,
  input logic       dma_wr_req_vld,
  input logic       dma_wr_req_rdy,
  input logic       reg2dp_ew_bypass,
  input logic       reg2dp_ew_alu_bypass,
  input logic [1:0] reg2dp_ew_alu_algo,
  input logic       reg2dp_output_dst,
  input logic       dfifo0_rd_prdy,
  input logic       dfifo1_rd_prdy,
  input logic       dfifo2_rd_prdy,
  input logic       dfifo3_rd_prdy,
  input logic       intr_req_pvld,
  input logic       dp2reg_done
);

  logic quiet;

  // equal compare or pdp destination
  assign quiet = (~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass & (reg2dp_ew_alu_algo == 2'h3))
                 | reg2dp_output_dst;

  // ================================================
  // request handshake
  // ================================================
  a_req_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (dma_wr_req_vld & ~dma_wr_req_rdy) |=> (dma_wr_req_vld & $stable(dma_wr_req_pd)))
    else $error("dma request dropped or changed while stalled");

  a_quiet_no_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(quiet & dma_wr_req_vld))
    else $error("dma request valid in quiet mode");

  // one lane popped at a time
  a_lane_onehot: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $onehot0({dfifo3_rd_prdy, dfifo2_rd_prdy, dfifo1_rd_prdy, dfifo0_rd_prdy}))
    else $error("more than one dfifo ready");

  // ================================================
  // layer end
  // ================================================
  a_done_follows: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    intr_req_pvld |=> dp2reg_done)
    else $error("done missing after interrupt request");

  a_done_cause: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |-> $past(intr_req_pvld))
    else $error("done without interrupt request one cycle before");

endmodule

bind sdp_wdma_dat_out sdp_wdma_dat_out_sva u_sva (
  .nvdla_core_clk       (nvdla_core_clk),
  .nvdla_core_rstn      (nvdla_core_rstn),
  .dma_wr_req_pd        (dma_wr_req_pd),
  .dma_wr_req_vld       (dma_wr_req_vld),
  .dma_wr_req_rdy       (dma_wr_req_rdy),
  .reg2dp_ew_bypass     (reg2dp_ew_bypass),
  .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
  .reg2dp_ew_alu_algo   (reg2dp_ew_alu_algo),
  .reg2dp_output_dst    (reg2dp_output_dst),
  .dfifo0_rd_prdy       (dfifo0_rd_prdy),
  .dfifo1_rd_prdy       (dfifo1_rd_prdy),
  .dfifo2_rd_prdy       (dfifo2_rd_prdy),
  .dfifo3_rd_prdy       (dfifo3_rd_prdy),
  .intr_req_pvld        (intr_req_pvld),
  .dp2reg_done          (dp2reg_done)
);

// File: dv/tb_sdp_wdma_dat_out.sv
/*
 * Testbench for the SDP write-DMA data output stage.
 * Random commands and lane words from a fixed seed, random lane gaps and
 * DMA back-pressure. Packets are compared with a queue model, and done,
 * interrupt and unequal status are checked every cycle.
 */
`timescale 1ns/1ps
`include "sdp_wdma_defs.svh"

module tb_sdp_wdma_dat_out import sdp_wdma_pkg::*; ();

  localparam int MAX_SIZE    = 15;
  localparam int TOTAL_CMDS  = 32;
  localparam int WDOG_CYCLES = TOTAL_CMDS * (MAX_SIZE + 2) * 200 + 1000;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  wdma_cmd_t  cmd2dat_dma_pd = '0;
  logic       cmd2dat_dma_pvld = 1'b0;
  logic       cmd2dat_dma_prdy;
  lane_word_t lane_pd [4] = '{default: '0};
  logic [3:0] lane_pvld = '0;
  logic [3:0] lane_prdy;
  dma_req_t   dma_wr_req_pd;
  logic       dma_wr_req_vld;
  logic       dma_wr_req_rdy = 1'b0;
  logic       reg2dp_ew_bypass;
  logic       reg2dp_ew_alu_bypass;
  logic [1:0] reg2dp_ew_alu_algo;
  logic       reg2dp_output_dst;
  logic       reg2dp_interrupt_ptr;
  logic       op_load;
  logic       dp2reg_done;
  logic       dp2reg_status_unequal;
  logic       intr_req_ptr;
  logic       intr_req_pvld;

  // ================================================
  // model state
  // ================================================
  integer     seed = 32'hb715_1045;
  wdma_cmd_t  cmd_q[$];
  wdma_cmd_t  inflight[$];
  lane_word_t lane_q[4][$];
  dma_req_t   exp_q[$];
  logic       quiet_mode = 1'b0;
  logic       exp_unequal = 1'b0;
  logic       done_due = 1'b0;
  logic       cmd_fire = 1'b0;
  logic [3:0] lane_fire = '0;
  logic       stall_pend = 1'b0;
  dma_req_t   stall_pd = '0;
  int         beat_idx = 0;
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         err_mark = 0;

  sdp_wdma_dat_out sdp_wdma_dat_out_inst (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .cmd2dat_dma_pd        (cmd2dat_dma_pd),
    .cmd2dat_dma_pvld      (cmd2dat_dma_pvld),
    .cmd2dat_dma_prdy      (cmd2dat_dma_prdy),
    .dfifo0_rd_pd          (lane_pd[0]),
    .dfifo0_rd_pvld        (lane_pvld[0]),
    .dfifo0_rd_prdy        (lane_prdy[0]),
    .dfifo1_rd_pd          (lane_pd[1]),
    .dfifo1_rd_pvld        (lane_pvld[1]),
    .dfifo1_rd_prdy        (lane_prdy[1]),
    .dfifo2_rd_pd          (lane_pd[2]),
    .dfifo2_rd_pvld        (lane_pvld[2]),
    .dfifo2_rd_prdy        (lane_prdy[2]),
    .dfifo3_rd_pd          (lane_pd[3]),
    .dfifo3_rd_pvld        (lane_pvld[3]),
    .dfifo3_rd_prdy        (lane_prdy[3]),
    .dma_wr_req_pd         (dma_wr_req_pd),
    .dma_wr_req_vld        (dma_wr_req_vld),
    .dma_wr_req_rdy        (dma_wr_req_rdy),
    .reg2dp_ew_bypass      (reg2dp_ew_bypass),
    .reg2dp_ew_alu_bypass  (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo    (reg2dp_ew_alu_algo),
    .reg2dp_output_dst     (reg2dp_output_dst),
    .reg2dp_interrupt_ptr  (reg2dp_interrupt_ptr),
    .op_load               (op_load),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .intr_req_ptr          (intr_req_ptr),
    .intr_req_pvld         (intr_req_pvld)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  // bound from the worst case beat count of all tests
  initial begin
    repeat (WDOG_CYCLES) @(posedge nvdla_core_clk);
    $display("timeout: run did not finish within %0d clock cycles", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ================================================
  // helpers
  // ================================================
  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic coin(input int pct);
    return (rand32() % 32'd100) < pct[31:0];
  endfunction

  // type 0, byte address, size, ack on cube end
  function automatic dma_req_t make_cmd_pkt(input wdma_cmd_t c);
    dma_req_t p;
    p = '0;
    p[31:0] = {c.addr, 3'b000};
    p[44:32] = c.size;
    p[`SDP_WDMA_REQ_ACK_BIT] = c.cube_end;
    p[`SDP_WDMA_REQ_TYPE_BIT] = 1'b0;
    return p;
  endfunction

  // type 1, single lane mask
  function automatic dma_req_t make_dat_pkt(input lane_word_t w);
    dma_req_t p;
    p = '0;
    p[63:0] = w;
    p[`SDP_WDMA_REQ_MASK_BIT] = 1'b1;
    p[`SDP_WDMA_REQ_TYPE_BIT] = 1'b1;
    return p;
  endfunction

  task automatic check_req(input dma_req_t got, input dma_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: dma_wr_req_pd got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // clear of the edge, no race with driver or monitor
  task automatic settle_after_edge();
    @(posedge nvdla_core_clk);
    #1;
  endtask

  task automatic set_cfg(input logic bypass, input logic alu_bypass,
                         input logic [1:0] algo, input logic dst);
    logic ptr;
    settle_after_edge();
    ptr = coin(50);
    @(posedge nvdla_core_clk);
    reg2dp_ew_bypass     <= bypass;
    reg2dp_ew_alu_bypass <= alu_bypass;
    reg2dp_ew_alu_algo   <= algo;
    reg2dp_output_dst    <= dst;
    reg2dp_interrupt_ptr <= ptr;
    quiet_mode           <= (~bypass & ~alu_bypass & (algo == 2'd3)) | dst;
  endtask

  task automatic pulse_op_load();
    @(posedge nvdla_core_clk);
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
  endtask

  // lane data first, beat b on lane b mod 4, last command ends the cube
  task automatic queue_cmds(input int n, input logic zero_words);
    wdma_cmd_t   c;
    lane_word_t  w;
    logic [31:0] r;
    settle_after_edge();
    for (int i = 0; i < n; i++) begin
      r = rand32();
      c.addr = r[28:0];
      r = rand32();
      c.size = {9'd0, r[3:0]};
      c.odd = r[8];
      c.cube_end = (i == n - 1) | (r[13:12] == 2'd0);
      if (!quiet_mode) exp_q.push_back(make_cmd_pkt(c));
      for (int b = 0; b <= int'(c.size); b++) begin
        w = zero_words ? '0 : {rand32(), rand32()};
        lane_q[b % 4].push_back(w);
        if (!quiet_mode) exp_q.push_back(make_dat_pkt(w));
      end
      cmd_q.push_back(c);
    end
  endtask

  task automatic wait_idle();
    settle_after_edge();
    while (cmd_q.size() != 0 || inflight.size() != 0 || cmd2dat_dma_pvld) begin
      settle_after_edge();
    end
    repeat (3) settle_after_edge();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected DMA packets never arrived", exp_q.size());
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // ================================================
  // driver, holds valid until taken
  // ================================================
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (cmd_fire) cmd_q.delete(0);
      if (!cmd2dat_dma_pvld || cmd_fire) begin
        if (cmd_q.size() > 0 && coin(70)) begin
          cmd2dat_dma_pvld <= 1'b1;
          cmd2dat_dma_pd   <= cmd_q[0];
        end else begin
          cmd2dat_dma_pvld <= 1'b0;
        end
      end
      for (int l = 0; l < 4; l++) begin
        if (lane_fire[l]) lane_q[l].delete(0);
        // random gaps on each lane
        if (!lane_pvld[l] || lane_fire[l]) begin
          if (lane_q[l].size() > 0 && coin(75)) begin
            lane_pvld[l] <= 1'b1;
            lane_pd[l]   <= lane_q[l][0];
          end else begin
            lane_pvld[l] <= 1'b0;
          end
        end
      end
      dma_wr_req_rdy <= coin(60);
    end
  end

  // ================================================
  // monitor, mid cycle where inputs are settled
  // ================================================
  always @(negedge nvdla_core_clk) begin
    logic      exp_intr;
    logic      nz;
    logic      hold_full;
    logic      cmd_done;
    wdma_cmd_t cur;
    if (nvdla_core_rstn) begin
      exp_intr  = 1'b0;
      nz        = 1'b0;
      cmd_done  = 1'b0;
      hold_full = (inflight.size() != 0);
      cmd_fire  = cmd2dat_dma_pvld & cmd2dat_dma_prdy;
      lane_fire = lane_pvld & lane_prdy;
      // stalled packet must not move
      if (stall_pend) begin
        check_flag(dma_wr_req_vld, 1'b1, "dma_wr_req_vld held under stall");
        check_req(dma_wr_req_pd, stall_pd);
      end
      stall_pend = dma_wr_req_vld & ~dma_wr_req_rdy;
      stall_pd   = dma_wr_req_pd;
      if (dma_wr_req_vld & dma_wr_req_rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERR %0t: DMA request %h with no packet expected", $time, dma_wr_req_pd);
        end else begin
          check_req(dma_wr_req_pd, exp_q.pop_front());
        end
      end
      if (quiet_mode) check_flag(dma_wr_req_vld, 1'b0, "dma_wr_req_vld in quiet mode");
      check_flag($onehot0(lane_prdy), 1'b1, "single dfifo ready");
      // beat count per command in flight
      for (int l = 0; l < 4; l++) begin
        if (lane_fire[l]) begin
          if (inflight.size() == 0) begin
            errors++;
            $display("lane %0d was popped with no command in flight at %0t", l, $time);
          end else begin
            check_flag((l % 4) == (beat_idx % 4), 1'b1, "lane order");
            nz = nz | (|lane_pd[l]);
            cur = inflight[0];
            beat_idx++;
            if (beat_idx == int'(cur.size) + 1) begin
              exp_intr = cur.cube_end;
              cmd_done = 1'b1;
              inflight.delete(0);
              beat_idx = 0;
            end
          end
        end
      end
      // hold register free, or its last beat leaving now
      check_flag(cmd2dat_dma_prdy, ~hold_full | cmd_done, "cmd2dat_dma_prdy");
      check_flag(intr_req_pvld, exp_intr, "intr_req_pvld");
      if (intr_req_pvld) check_flag(intr_req_ptr, reg2dp_interrupt_ptr, "intr_req_ptr");
      check_flag(dp2reg_done, done_due, "dp2reg_done");
      done_due = exp_intr;
      check_flag(dp2reg_status_unequal, exp_unequal, "dp2reg_status_unequal");
      if (op_load) begin
        exp_unequal = 1'b0;
      end else if (nz) begin
        exp_unequal = 1'b1;
      end
      if (cmd_fire) inflight.push_back(cmd2dat_dma_pd);
    end
  end

  // ================================================
  // test sequence
  // ================================================
  initial begin
    nvdla_core_rstn      = 1'b0;
    reg2dp_ew_bypass     = 1'b1;
    reg2dp_ew_alu_bypass = 1'b1;
    reg2dp_ew_alu_algo   = 2'd0;
    reg2dp_output_dst    = 1'b0;
    reg2dp_interrupt_ptr = 1'b0;
    op_load              = 1'b0;
    repeat (2) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    settle_after_edge();

    // idle outputs out of reset
    check_flag(dma_wr_req_vld, 1'b0, "dma_wr_req_vld after reset");
    check_flag(|lane_prdy, 1'b0, "dfifo prdy after reset");
    check_flag(dp2reg_done, 1'b0, "dp2reg_done after reset");
    check_flag(intr_req_pvld, 1'b0, "intr_req_pvld after reset");
    check_flag(dp2reg_status_unequal, 1'b0, "unequal after reset");
    report_test("reset_values");

    // full dma path with back-pressure
    set_cfg(1'b1, 1'b1, 2'd0, 1'b0);
    queue_cmds(12, 1'b0);
    wait_idle();
    report_test("dma_packets");

    // equal compare, all-zero layer
    set_cfg(1'b0, 1'b0, 2'd3, 1'b0);
    pulse_op_load();
    queue_cmds(6, 1'b1);
    wait_idle();
    check_flag(dp2reg_status_unequal, 1'b0, "unequal after zero layer");
    report_test("eql_zero_layer");

    // same mode, words now differ from zero
    queue_cmds(6, 1'b0);
    wait_idle();
    check_flag(dp2reg_status_unequal, 1'b1, "unequal after non-zero layer");
    report_test("eql_nonzero_layer");

    // output routed to pdp
    set_cfg(1'b1, 1'b1, 2'd0, 1'b1);
    pulse_op_load();
    queue_cmds(8, 1'b0);
    wait_idle();
    check_flag(dp2reg_status_unequal, 1'b1, "unequal after pdp layer");
    report_test("pdp_quiet");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: logic/sdp_wdma_cmd_seq.sv
/*
 * Command holding and packet sequencing for the write-DMA data output.
 * Takes one command, offers its command packet, then counts size+1
 * data beats. A new command may load while the last beat is accepted.
 */
`timescale 1ns/1ps
`include "sdp_wdma_defs.svh"

module sdp_wdma_cmd_seq import sdp_wdma_pkg::*; (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  input  wdma_cmd_t cmd2dat_dma_pd,
  input  logic      cmd2dat_dma_pvld,
  output logic      cmd2dat_dma_prdy,
  input  logic      dat_vld,
  input  logic      wr_rdy,
  output wdma_cmd_t cur_cmd,
  output logic      cmd_pkt_vld,
  output logic      cmd_phase,
  output lane_sel_t lane,
  output logic      dat_rdy,
  output logic      dat_accept,
  output logic      layer_end
);

  logic                        cmd_vld;
  logic                        cmd_accept;
  logic                        is_last_beat;
  logic [`SDP_WDMA_SIZE_W-1:0] beat_cnt;

  // ================================================
  // command hold register
  // ================================================
  // free when empty or when the last beat leaves
  assign cmd2dat_dma_prdy = ~cmd_vld | (dat_accept & is_last_beat);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_vld <= 1'b0;
    end else if (cmd2dat_dma_prdy) begin
      cmd_vld <= cmd2dat_dma_pvld;
    end
  end

  // payload only
  always_ff @(posedge nvdla_core_clk) begin
    if (cmd2dat_dma_pvld & cmd2dat_dma_prdy) begin
      cur_cmd <= cmd2dat_dma_pd;
    end
  end

  // ================================================
  // cmd / dat phase
  // ================================================
  assign cmd_pkt_vld = cmd_phase & cmd_vld;
  assign cmd_accept  = cmd_pkt_vld & wr_rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_phase <= 1'b1;
    end else if (cmd_accept) begin
      cmd_phase <= 1'b0;
    end else if (dat_accept & is_last_beat) begin
      cmd_phase <= 1'b1;
    end
  end

  // ================================================
  // beat counter
  // ================================================
  // size holds beats minus one
  assign is_last_beat = (beat_cnt == cur_cmd.size);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_cnt <= '0;
    end else if (dat_accept) begin
      if (is_last_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // round robin lane, restarts at 0 per command
  assign lane       = beat_cnt[$bits(lane_sel_t)-1:0];
  assign dat_rdy    = ~cmd_phase & wr_rdy;
  assign dat_accept = dat_vld & dat_rdy;

  // last beat of the cube
  assign layer_end  = dat_accept & is_last_beat & cur_cmd.cube_end;

endmodule

// File: logic/sdp_wdma_dat_out.sv
/*
 * Top of the SDP write-DMA data output stage.
 * Turns write commands and four data fifo lanes into DMA write requests,
 * and reports layer done, interrupt and unequal status.
 */
`timescale 1ns/1ps

module sdp_wdma_dat_out import sdp_wdma_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  wdma_cmd_t  cmd2dat_dma_pd,
  input  logic       cmd2dat_dma_pvld,
  output logic       cmd2dat_dma_prdy,
  input  lane_word_t dfifo0_rd_pd,
  input  logic       dfifo0_rd_pvld,
  output logic       dfifo0_rd_prdy,
  input  lane_word_t dfifo1_rd_pd,
  input  logic       dfifo1_rd_pvld,
  output logic       dfifo1_rd_prdy,
  input  lane_word_t dfifo2_rd_pd,
  input  logic       dfifo2_rd_pvld,
  output logic       dfifo2_rd_prdy,
  input  lane_word_t dfifo3_rd_pd,
  input  logic       dfifo3_rd_pvld,
  output logic       dfifo3_rd_prdy,
  output dma_req_t   dma_wr_req_pd,
  output logic       dma_wr_req_vld,
  input  logic       dma_wr_req_rdy,
  input  logic       reg2dp_ew_bypass,
  input  logic       reg2dp_ew_alu_bypass,
  input  logic [1:0] reg2dp_ew_alu_algo,
  input  logic       reg2dp_output_dst,
  input  logic       reg2dp_interrupt_ptr,
  input  logic       op_load,
  output logic       dp2reg_done,
  output logic       dp2reg_status_unequal,
  output logic       intr_req_ptr,
  output logic       intr_req_pvld
);

  wdma_cmd_t  cur_cmd;
  logic       cmd_pkt_vld;
  logic       cmd_phase;
  lane_sel_t  lane;
  logic       dat_rdy;
  logic       dat_accept;
  logic       layer_end;
  logic       dat_vld;
  lane_word_t dat_word;
  logic       wr_rdy;

  // ================================================
  // command sequencer
  // ================================================
  sdp_wdma_cmd_seq u_cmd_seq (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .cmd2dat_dma_pd   (cmd2dat_dma_pd),
    .cmd2dat_dma_pvld (cmd2dat_dma_pvld),
    .cmd2dat_dma_prdy (cmd2dat_dma_prdy),
    .dat_vld          (dat_vld),
    .wr_rdy           (wr_rdy),
    .cur_cmd          (cur_cmd),
    .cmd_pkt_vld      (cmd_pkt_vld),
    .cmd_phase        (cmd_phase),
    .lane             (lane),
    .dat_rdy          (dat_rdy),
    .dat_accept       (dat_accept),
    .layer_end        (layer_end)
  );

  // lane select
  sdp_wdma_lane_gather u_lane_gather (
    .lane           (lane),
    .dat_rdy        (dat_rdy),
    .dfifo0_rd_pd   (dfifo0_rd_pd),
    .dfifo0_rd_pvld (dfifo0_rd_pvld),
    .dfifo0_rd_prdy (dfifo0_rd_prdy),
    .dfifo1_rd_pd   (dfifo1_rd_pd),
    .dfifo1_rd_pvld (dfifo1_rd_pvld),
    .dfifo1_rd_prdy (dfifo1_rd_prdy),
    .dfifo2_rd_pd   (dfifo2_rd_pd),
    .dfifo2_rd_pvld (dfifo2_rd_pvld),
    .dfifo2_rd_prdy (dfifo2_rd_prdy),
    .dfifo3_rd_pd   (dfifo3_rd_pd),
    .dfifo3_rd_pvld (dfifo3_rd_pvld),
    .dfifo3_rd_prdy (dfifo3_rd_prdy),
    .dat_vld        (dat_vld),
    .dat_word       (dat_word)
  );

  // dma request out
  sdp_wdma_req_pack u_req_pack (
    .reg2dp_ew_bypass     (reg2dp_ew_bypass),
    .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo   (reg2dp_ew_alu_algo),
    .reg2dp_output_dst    (reg2dp_output_dst),
    .dma_wr_req_rdy       (dma_wr_req_rdy),
    .cur_cmd              (cur_cmd),
    .cmd_pkt_vld          (cmd_pkt_vld),
    .cmd_phase            (cmd_phase),
    .dat_vld              (dat_vld),
    .dat_word             (dat_word),
    .dma_wr_req_pd        (dma_wr_req_pd),
    .dma_wr_req_vld       (dma_wr_req_vld),
    .wr_rdy               (wr_rdy)
  );

  // status and interrupt
  sdp_wdma_layer_status u_layer_status (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .op_load               (op_load),
    .dat_accept            (dat_accept),
    .dat_word              (dat_word),
    .layer_end             (layer_end),
    .reg2dp_interrupt_ptr  (reg2dp_interrupt_ptr),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .intr_req_ptr          (intr_req_ptr),
    .intr_req_pvld         (intr_req_pvld)
  );

endmodule

// File: logic/sdp_wdma_defs.svh
/*
 * Widths and packet bit positions for the SDP write-DMA data output stage.
 * Included by the package and by any module that slices raw vectors.
 */
`ifndef SDP_WDMA_DEFS_SVH
`define SDP_WDMA_DEFS_SVH

// command payload
`define SDP_WDMA_ADDR_W       29
`define SDP_WDMA_SIZE_W       13
`define SDP_WDMA_CMD_W        44

// data fifo lanes
`define SDP_WDMA_LANES        4
`define SDP_WDMA_LANE_W       64

// dma write request, atom address becomes a byte address
`define SDP_WDMA_REQ_W        66
`define SDP_WDMA_ATOM_SHIFT   3
`define SDP_WDMA_BYTE_ADDR_W  (`SDP_WDMA_ADDR_W + `SDP_WDMA_ATOM_SHIFT)

// packet bit positions
`define SDP_WDMA_REQ_TYPE_BIT 65
`define SDP_WDMA_REQ_ACK_BIT  45
`define SDP_WDMA_REQ_MASK_BIT 64

`endif

// File: logic/sdp_wdma_lane_gather.sv
/*
 * Data fifo lane select for the write-DMA data output.
 * Presents the valid and word of the current lane and pops only that lane.
 */
`timescale 1ns/1ps
`include "sdp_wdma_defs.svh"

module sdp_wdma_lane_gather import sdp_wdma_pkg::*; (
  input  lane_sel_t  lane,
  input  logic       dat_rdy,
  input  lane_word_t dfifo0_rd_pd,
  input  logic       dfifo0_rd_pvld,
  output logic       dfifo0_rd_prdy,
  input  lane_word_t dfifo1_rd_pd,
  input  logic       dfifo1_rd_pvld,
  output logic       dfifo1_rd_prdy,
  input  lane_word_t dfifo2_rd_pd,
  input  logic       dfifo2_rd_pvld,
  output logic       dfifo2_rd_prdy,
  input  lane_word_t dfifo3_rd_pd,
  input  logic       dfifo3_rd_pvld,
  output logic       dfifo3_rd_prdy,
  output logic       dat_vld,
  output lane_word_t dat_word
);

  lane_word_t                 lane_pd [`SDP_WDMA_LANES];
  logic [`SDP_WDMA_LANES-1:0] lane_pvld;
  logic [`SDP_WDMA_LANES-1:0] lane_prdy;

  // gather loose lane ports
  assign lane_pd[0] = dfifo0_rd_pd;
  assign lane_pd[1] = dfifo1_rd_pd;
  assign lane_pd[2] = dfifo2_rd_pd;
  assign lane_pd[3] = dfifo3_rd_pd;
  assign lane_pvld  = {dfifo3_rd_pvld, dfifo2_rd_pvld, dfifo1_rd_pvld, dfifo0_rd_pvld};

  // single atom per beat
  assign dat_vld  = lane_pvld[lane];
  assign dat_word = lane_pd[lane];

  // one-hot ready on the selected lane
  always_comb begin
    lane_prdy       = '0;
    lane_prdy[lane] = dat_rdy;
  end

  assign dfifo0_rd_prdy = lane_prdy[0];
  assign dfifo1_rd_prdy = lane_prdy[1];
  assign dfifo2_rd_prdy = lane_prdy[2];
  assign dfifo3_rd_prdy = lane_prdy[3];

endmodule

// File: logic/sdp_wdma_layer_status.sv
/*
 * Layer status for the write-DMA data output.
 * Sticky unequal flag for equal-compare mode, done pulse and interrupt.
 */
`timescale 1ns/1ps

module sdp_wdma_layer_status import sdp_wdma_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  logic       op_load,
  input  logic       dat_accept,
  input  lane_word_t dat_word,
  input  logic       layer_end,
  input  logic       reg2dp_interrupt_ptr,
  output logic       dp2reg_done,
  output logic       dp2reg_status_unequal,
  output logic       intr_req_ptr,
  output logic       intr_req_pvld
);

  // ================================================
  // unequal status
  // ================================================
  // any non-zero word seen since op_load
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_status_unequal <= 1'b0;
    end else if (op_load) begin
      dp2reg_status_unequal <= 1'b0;
    end else if (dat_accept & (|dat_word)) begin
      dp2reg_status_unequal <= 1'b1;
    end
  end

  // done one cycle after the interrupt request
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_end;
    end
  end

  // intr goes out with the last beat
  assign intr_req_pvld = layer_end;
  assign intr_req_ptr  = reg2dp_interrupt_ptr;

endmodule

// File: logic/sdp_wdma_pkg.sv
/*
 * Payload types of the SDP write-DMA data output stage.
 * Shared by the RTL and the testbench through a wildcard import.
 */
`include "sdp_wdma_defs.svh"

package sdp_wdma_pkg;

  // command from the wdma command path, odd bit carried but ignored
  typedef struct packed {
    logic                        cube_end;
    logic                        odd;
    logic [`SDP_WDMA_SIZE_W-1:0] size;
    logic [`SDP_WDMA_ADDR_W-1:0] addr;
  } wdma_cmd_t;

  // dma write request packet, raw vector
  // type 0: byte addr [31:0], size [44:32], require_ack [45]
  // type 1: data [63:0], mask [64]
  typedef logic [`SDP_WDMA_REQ_W-1:0] dma_req_t;

  // data fifo lane index and lane word
  typedef logic [$clog2(`SDP_WDMA_LANES)-1:0] lane_sel_t;
  typedef logic [`SDP_WDMA_LANE_W-1:0] lane_word_t;

endpackage

// File: logic/sdp_wdma_req_pack.sv
/*
 * DMA write request builder for the write-DMA data output.
 * Decodes quiet mode, muxes the command or data packet, and makes the
 * internal ready that the sequencer and lane select run on.
 */
`timescale 1ns/1ps
`include "sdp_wdma_defs.svh"

module sdp_wdma_req_pack import sdp_wdma_pkg::*; (
  input  logic       reg2dp_ew_bypass,
  input  logic       reg2dp_ew_alu_bypass,
  input  logic [1:0] reg2dp_ew_alu_algo,
  input  logic       reg2dp_output_dst,
  input  logic       dma_wr_req_rdy,
  input  wdma_cmd_t  cur_cmd,
  input  logic       cmd_pkt_vld,
  input  logic       cmd_phase,
  input  logic       dat_vld,
  input  lane_word_t dat_word,
  output dma_req_t   dma_wr_req_pd,
  output logic       dma_wr_req_vld,
  output logic       wr_rdy
);

  logic cfg_mode_eql;
  logic cfg_mode_pdp;
  logic cfg_mode_quiet;

  // ================================================
  // quiet mode decode
  // ================================================
  // equal compare, both bypasses off and algo 3
  assign cfg_mode_eql   = ~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass
                          & (reg2dp_ew_alu_algo == 2'h3);
  // output goes to pdp
  assign cfg_mode_pdp   = reg2dp_output_dst;
  assign cfg_mode_quiet = cfg_mode_eql | cfg_mode_pdp;

  // dma never stalls us in quiet mode
  assign wr_rdy = cfg_mode_quiet | dma_wr_req_rdy;

  // ================================================
  // packet mux
  // ================================================
  assign dma_wr_req_vld = (cmd_pkt_vld | (~cmd_phase & dat_vld)) & ~cfg_mode_quiet;

  always_comb begin
    dma_wr_req_pd = '0;
    if (cmd_phase) begin
      // cmd pkt, byte address from atom address
      dma_wr_req_pd[`SDP_WDMA_BYTE_ADDR_W-1:0] =
        {cur_cmd.addr, {`SDP_WDMA_ATOM_SHIFT{1'b0}}};
      dma_wr_req_pd[`SDP_WDMA_BYTE_ADDR_W +: `SDP_WDMA_SIZE_W] = cur_cmd.size;
      dma_wr_req_pd[`SDP_WDMA_REQ_ACK_BIT]  = cur_cmd.cube_end;
      dma_wr_req_pd[`SDP_WDMA_REQ_TYPE_BIT] = 1'b0;
    end else begin
      // dat pkt, one atom so mask is a constant 1
      dma_wr_req_pd[`SDP_WDMA_LANE_W-1:0]   = dat_word;
      dma_wr_req_pd[`SDP_WDMA_REQ_MASK_BIT] = 1'b1;
      dma_wr_req_pd[`SDP_WDMA_REQ_TYPE_BIT] = 1'b1;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the write-DMA data output testbench with Verilator.
# Pass or fail is decided by the pass line in sim.log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_sdp_wdma_dat_out
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile step returned status $status"
  exit 1
fi

./obj_dir/Vtb_sdp_wdma_dat_out +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi

// File: src.f
+incdir+logic
logic/sdp_wdma_pkg.sv
logic/sdp_wdma_cmd_seq.sv
logic/sdp_wdma_lane_gather.sv
logic/sdp_wdma_req_pack.sv
logic/sdp_wdma_layer_status.sv
logic/sdp_wdma_dat_out.sv
dv/sdp_wdma_dat_out_sva.sv
dv/tb_sdp_wdma_dat_out.sv
